//--- logic/neuron_config.svh
`ifndef NEURON_CONFIG_SVH
`define NEURON_CONFIG_SVH

`define NEURON_INPUTS 15 // Inputs feeding one neuron.

`define TREE_LEVELS 4 // Adder levels to reduce the inputs to one sum.

`define NEURON_LATENCY 6 // Cycles from in_valid to out_valid.

`endif

//--- logic/neuron_pkg.sv
`include "neuron_config.svh"

package neuron_pkg;

	typedef logic [31:0] fp32_t;

	typedef fp32_t fp32_vec_t [`NEURON_INPUTS];

	// Trained weights of this neuron. Index 0 pairs with x[0].
	parameter fp32_vec_t neuron_weights = '{
		32'b00111110110000111011011110001100,
		32'b00111110111110011001011010111010,
		32'b00111111001011100101010000001111,
		32'b00111110011010010010100000010010,
		32'b10111100011111000010110111100000,
		32'b00111101000001001011011011111111,
		32'b10111111000000100010011010110011,
		32'b00111011000101000111010111000000,
		32'b00111101010001000110001111011011,
		32'b10111110110100011011010100000101,
		32'b10111110000001001100111110011110,
		32'b10111110100011010110001100101001,
		32'b00111101110011010100110101000101,
		32'b10111110110001001101001101111001,
		32'b10111101101000010101101011101100
	};

endpackage

//--- logic/fp32_mult.sv
`timescale 1ns/1ps

module fp32_mult import neuron_pkg::*;
(
	input fp32_t a,
	input fp32_t b,
	output fp32_t p
);

	logic sign;
	logic [7:0] exp_a;
	logic [7:0] exp_b;
	logic [23:0] man_a;
	logic [23:0] man_b;
	logic zero_in;
	logic [47:0] product;
	logic [22:0] frac;
	logic guard;
	logic sticky;
	logic round_up;
	logic [23:0] frac_rnd;
	logic signed [9:0] exp_norm;
	logic signed [9:0] exp_final;

	assign sign = a[31] ^ b[31];
	assign exp_a = a[30:23];
	assign exp_b = b[30:23];
	assign man_a = {1'b1, a[22:0]};
	assign man_b = {1'b1, b[22:0]};
	assign zero_in = (exp_a == 8'd0) || (exp_b == 8'd0); // Denormals count as zero.

	assign product = man_a * man_b;

	// Product of two 1.x values is in [1,4), so at most one right shift.
	always_comb
	begin
		if (product[47])
		begin
			frac = product[46:24];
			guard = product[23];
			sticky = |product[22:0];
			exp_norm = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd126;
		end
		else
		begin
			frac = product[45:23];
			guard = product[22];
			sticky = |product[21:0];
			exp_norm = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd127;
		end
	end

	assign round_up = guard & (sticky | frac[0]); // Round half to even.
	assign frac_rnd = {1'b0, frac} + {23'd0, round_up};
	assign exp_final = exp_norm + $signed({9'd0, frac_rnd[23]}); // Mantissa carry.

	always_comb
	begin
		if (zero_in || exp_final <= 10'sd0)
		begin
			p = {sign, 31'd0};
		end
		else if (exp_final >= 10'sd255)
		begin
			p = {sign, 8'hfe, 23'h7fffff}; // Largest finite value.
		end
		else
		begin
			p = {sign, exp_final[7:0], frac_rnd[22:0]};
		end
	end

endmodule

//--- logic/fp32_add.sv
`timescale 1ns/1ps

module fp32_add import neuron_pkg::*;
(
	input fp32_t a,
	input fp32_t b,
	output fp32_t s
);

	fp32_t a_ftz;
	fp32_t b_ftz;
	fp32_t big;
	fp32_t small_op;
	logic swap;
	logic sub;
	logic [7:0] exp_big;
	logic [7:0] exp_small;
	logic [7:0] exp_diff;
	logic [26:0] ext_big;
	logic [26:0] ext_small;
	logic [26:0] shifted;
	logic [26:0] lost_mask;
	logic sticky;
	logic [26:0] aligned;
	logic [27:0] raw_sum;
	logic [4:0] lead_zeros;
	logic [26:0] norm;
	logic signed [9:0] exp_norm;
	logic [23:0] mant;
	logic round_up;
	logic [24:0] mant_rnd;
	logic signed [9:0] exp_final;
	logic zero_sign;

	// Denormal operands flush to a signed zero.
	assign a_ftz = (a[30:23] == 8'd0) ? {a[31], 31'd0} : a;
	assign b_ftz = (b[30:23] == 8'd0) ? {b[31], 31'd0} : b;

	assign swap = b_ftz[30:0] > a_ftz[30:0];
	assign big = swap ? b_ftz : a_ftz;
	assign small_op = swap ? a_ftz : b_ftz;
	assign sub = big[31] ^ small_op[31];

	assign exp_big = big[30:23];
	assign exp_small = small_op[30:23];
	assign exp_diff = exp_big - exp_small;

	// Layout is hidden bit, 23 fraction bits, then guard, round and sticky.
	assign ext_big = {exp_big != 8'd0, big[22:0], 3'b000};
	assign ext_small = {exp_small != 8'd0, small_op[22:0], 3'b000};

	assign shifted = ext_small >> exp_diff;
	assign lost_mask = ~({27{1'b1}} << exp_diff);
	assign sticky = |(ext_small & lost_mask);
	assign aligned = {shifted[26:1], shifted[0] | sticky};

	// Big has the larger magnitude, so the difference is never negative.
	assign raw_sum = sub ? ({1'b0, ext_big} - {1'b0, aligned})
		: ({1'b0, ext_big} + {1'b0, aligned});

	always_comb
	begin
		lead_zeros = 5'd27;
		for (int i = 0; i < 27; i++)
		begin
			if (raw_sum[i])
				lead_zeros = 5'(26 - i);
		end
	end

	always_comb
	begin
		if (raw_sum[27])
		begin
			norm = {raw_sum[27:2], raw_sum[1] | raw_sum[0]}; // Carry out.
			exp_norm = $signed({2'b00, exp_big}) + 10'sd1;
		end
		else
		begin
			norm = raw_sum[26:0] << lead_zeros;
			exp_norm = $signed({2'b00, exp_big}) - $signed({5'd0, lead_zeros});
		end
	end

	assign mant = norm[26:3];
	assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]); // Ties to even.
	assign mant_rnd = {1'b0, mant} + {24'd0, round_up};
	assign exp_final = exp_norm + $signed({9'd0, mant_rnd[24]});

	assign zero_sign = ~sub & big[31]; // Only -0 plus -0 keeps the sign.

	always_comb
	begin
		if (raw_sum == 28'd0)
		begin
			s = {zero_sign, 31'd0};
		end
		else if (exp_final <= 10'sd0)
		begin
			s = {big[31], 31'd0}; // Underflow.
		end
		else if (exp_final >= 10'sd255)
		begin
			s = {big[31], 8'hfe, 23'h7fffff};
		end
		else
		begin
			s = {big[31], exp_final[7:0], mant_rnd[22:0]};
		end
	end

endmodule

//--- logic/weight_mult_stage.sv
`timescale 1ns/1ps

`include "neuron_config.svh"

module weight_mult_stage import neuron_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fp32_vec_t x,
	output logic out_valid,
	output fp32_vec_t prod
);

	fp32_vec_t prod_comb;

	for (genvar i = 0; i < `NEURON_INPUTS; i++)
	begin : g_mult
		fp32_mult u_mult
		(
			.a(x[i]),
			.b(neuron_weights[i]),
			.p(prod_comb[i])
		);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
			prod <= prod_comb;
	end

endmodule

//--- logic/adder_tree_stage.sv
`timescale 1ns/1ps

module adder_tree_stage import neuron_pkg::*;
#(
	parameter int N_IN = 2
)
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fp32_t operands [N_IN],
	output logic out_valid,
	output fp32_t sums [(N_IN + 1) / 2]
);

	localparam int N_OUT = (N_IN + 1) / 2;
	localparam int N_PAIRS = N_IN / 2;

	fp32_t pair_sum [N_PAIRS];

	for (genvar i = 0; i < N_PAIRS; i++)
	begin : g_pair
		fp32_add u_add
		(
			.a(operands[2 * i]),
			.b(operands[2 * i + 1]),
			.s(pair_sum[i])
		);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			for (int i = 0; i < N_PAIRS; i++)
				sums[i] <= pair_sum[i];
			if (N_IN % 2 == 1)
				sums[N_OUT - 1] <= operands[N_IN - 1]; // Odd operand skips this level.
		end
	end

endmodule

//--- logic/neuron_node.sv
`timescale 1ns/1ps

`include "neuron_config.svh"

module neuron_node import neuron_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fp32_vec_t x,
	output logic out_valid,
	output fp32_t y
);

	localparam int L1_N = (`NEURON_INPUTS + 1) / 2;
	localparam int L2_N = (L1_N + 1) / 2;
	localparam int L3_N = (L2_N + 1) / 2;
	localparam int L4_N = (L3_N + 1) / 2;

	logic mult_valid;
	fp32_vec_t prod;
	logic l1_valid;
	fp32_t l1_sum [L1_N];
	logic l2_valid;
	fp32_t l2_sum [L2_N];
	logic l3_valid;
	fp32_t l3_sum [L3_N];
	logic l4_valid;
	fp32_t l4_sum [L4_N];

	weight_mult_stage u_mult_stage
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.x(x),
		.out_valid(mult_valid),
		.prod(prod)
	);

	adder_tree_stage #(.N_IN(`NEURON_INPUTS)) u_tree0
	(
		.clk(clk),
		.rst(rst),
		.in_valid(mult_valid),
		.operands(prod),
		.out_valid(l1_valid),
		.sums(l1_sum)
	);

	adder_tree_stage #(.N_IN(L1_N)) u_tree1
	(
		.clk(clk),
		.rst(rst),
		.in_valid(l1_valid),
		.operands(l1_sum),
		.out_valid(l2_valid),
		.sums(l2_sum)
	);

	adder_tree_stage #(.N_IN(L2_N)) u_tree2
	(
		.clk(clk),
		.rst(rst),
		.in_valid(l2_valid),
		.operands(l2_sum),
		.out_valid(l3_valid),
		.sums(l3_sum)
	);

	adder_tree_stage #(.N_IN(L3_N)) u_tree3
	(
		.clk(clk),
		.rst(rst),
		.in_valid(l3_valid),
		.operands(l3_sum),
		.out_valid(l4_valid),
		.sums(l4_sum)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= l4_valid;
	end

	always_ff @(posedge clk)
	begin
		if (l4_valid)
			y <= l4_sum[0][31] ? 32'd0 : l4_sum[0]; // ReLU turns -0 into +0 as well.
	end

endmodule

//--- tests/neuron_node_tb.sv
`timescale 1ns/1ps

`include "neuron_config.svh"

module neuron_node_tb import neuron_pkg::*;
();

	logic clk;
	logic rst;
	logic in_valid;
	fp32_vec_t x;
	logic out_valid;
	fp32_t y;

	integer seed = 54092;
	int edge_count = 0;
	int sent_count = 0;
	int recv_count = 0;
	string test_name = "reset";
	fp32_vec_t vec;
	fp32_t exp_q [$];
	int accept_q [$];

	neuron_node UUT
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.x(x),
		.out_valid(out_valid),
		.y(y)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		edge_count <= edge_count + 1; // Index of the latest rising edge.

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_fp32(input string name, input fp32_t expected, input fp32_t actual);
		if (actual !== expected)
			abort_run($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("** Error: %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	function automatic real fp32_to_real(input fp32_t f);
		if (f[30:23] == 8'd0)
			return f[31] ? -0.0 : 0.0; // Denormals flush to zero.
		return $bitstoreal({f[31], 11'(int'(f[30:23]) + 896), f[22:0], 29'd0});
	endfunction

	// Double to single with round to nearest even on the dropped 29 bits.
	function automatic fp32_t real_to_fp32(input real v);
		logic [63:0] d;
		logic [23:0] frac;
		logic round_up;
		int e;
		d = $realtobits(v);
		if (d[62:52] == 11'd0)
			return {d[63], 31'd0};
		e = int'(d[62:52]) - 896;
		round_up = d[28] & ((|d[27:0]) | d[29]);
		frac = {1'b0, d[51:29]} + 24'(round_up);
		if (frac[23])
			e = e + 1;
		if (e <= 0)
			return {d[63], 31'd0};
		if (e >= 255)
			return {d[63], 8'hfe, 23'h7fffff};
		return {d[63], 8'(e), frac[22:0]};
	endfunction

	// Products, then adjacent pairs per level with the odd last one passed on.
	function automatic fp32_t neuron_ref(input fp32_vec_t xv);
		fp32_t ops [`NEURON_INPUTS];
		int n;
		n = `NEURON_INPUTS;
		for (int i = 0; i < `NEURON_INPUTS; i++)
			ops[i] = real_to_fp32(fp32_to_real(xv[i]) * fp32_to_real(neuron_weights[i]));
		while (n > 1)
		begin
			for (int i = 0; i < n / 2; i++)
				ops[i] = real_to_fp32(fp32_to_real(ops[2 * i]) + fp32_to_real(ops[2 * i + 1]));
			if (n % 2 == 1)
				ops[n / 2] = ops[n - 1];
			n = (n + 1) / 2;
		end
		return ops[0][31] ? 32'd0 : ops[0]; // ReLU.
	endfunction

	task automatic randomize_vec();
		logic [31:0] r;
		logic [7:0] e;
		for (int i = 0; i < `NEURON_INPUTS; i++)
		begin
			r = $random(seed);
			e = 8'd120 + 8'({$random(seed)} % 32'd15);
			vec[i] = {r[31], e, r[22:0]};
		end
	endtask

	// Called 1 ns after a rising edge; the sample is taken at the next edge.
	task automatic send_sample(input fp32_vec_t v, input fp32_t expected);
		x = v;
		in_valid = 1'b1;
		exp_q.push_back(expected);
		accept_q.push_back(edge_count + 1);
		sent_count++;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 20)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("Timeout in %s: out_valid did not arrive within 20 cycles", test_name));
		idle_cycles(8); // Nothing else may come out.
	endtask

	// Sampled at the falling edge where y and out_valid are stable.
	always @(negedge clk)
	begin
		if (!rst && out_valid === 1'b1)
		begin
			recv_count++;
			if (exp_q.size() == 0)
				check_count({test_name, " result count"}, sent_count, recv_count);
			else
			begin
				check_fp32(test_name, exp_q.pop_front(), y);
				// The consumer takes out_valid at the next rising edge.
				check_count({test_name, " latency"}, `NEURON_LATENCY,
					edge_count + 1 - accept_q.pop_front());
			end
		end
		else if (!rst && out_valid !== 1'b0)
			abort_run("out_valid is unknown after reset");
	end

	initial
	begin
		int gap;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		for (int i = 0; i < `NEURON_INPUTS; i++)
			x[i] = 32'd0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_cycles(4);

		test_name = "single sample";
		randomize_vec();
		send_sample(vec, neuron_ref(vec));
		wait_results();

		test_name = "back-to-back stream";
		for (int k = 0; k < 200; k++)
		begin
			randomize_vec();
			send_sample(vec, neuron_ref(vec));
		end
		wait_results();

		test_name = "relu clamp";
		for (int i = 0; i < `NEURON_INPUTS; i++)
			vec[i] = {~neuron_weights[i][31], neuron_weights[i][30:0]}; // Every product negative.
		send_sample(vec, 32'd0);
		wait_results();

		test_name = "zero vector";
		for (int i = 0; i < `NEURON_INPUTS; i++)
			vec[i] = 32'd0;
		send_sample(vec, 32'd0);
		wait_results();

		test_name = "gapped strobes";
		for (int k = 0; k < 40; k++)
		begin
			randomize_vec();
			send_sample(vec, neuron_ref(vec));
			gap = {$random(seed)} % 4;
			idle_cycles(gap);
		end
		wait_results();

		$display("No errors");
		$finish;
	end

endmodule

//--- sources.f
+incdir+logic
logic/neuron_pkg.sv
logic/fp32_mult.sv
logic/fp32_add.sv
logic/weight_mult_stage.sv
logic/adder_tree_stage.sv
logic/neuron_node.sv
tests/neuron_node_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the neuron testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module neuron_node_tb \
	-Mdir obj_dir -o neuron_node_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/neuron_node_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation completed successfully"
exit 0
